// File: build.f
rtl/mem_op_pkg.sv
rtl/wb_pkg.sv
rtl/cache_ctr.sv
rtl/bus_timeout.sv
rtl/load_align.sv
rtl/mem_access_fsm.sv
rtl/mem_stage.sv
verification/mem_stage_props.sv
verification/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module mem_stage_tb -o mem_stage_sim

status=0
output=$(./obj_dir/mem_stage_sim 2>&1) || status=$?
echo "$output"
[ "$status" -eq 0 ]
echo "$output" | grep -qx "sim passed"

// File: verification/mem_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_tb;
    import mem_op_pkg::*;
    import wb_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int ROUNDS          = 2;
    localparam int NUM_REQ         = ROUNDS * 36 + 4 + 1 + 2;
    localparam int WATCHDOG_CYCLES = NUM_REQ * (BUS_TIMEOUT + 8) + 200;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 issue;
    logic [31:0]          ctr;
    logic [31:0]          rrj;
    logic [31:0]          imm;
    logic [31:0]          rrd;
    logic [15:0]          excp_arg;
    logic                 busy;
    logic                 done;
    logic [WB_DATA_W-1:0] load_data;
    logic                 align_error;
    logic                 bus_error;
    logic                 cache_op_valid;
    logic [31:0]          cache_opcode;
    logic                 icache_op;
    logic                 dcache_op;
    logic                 l2cache_op;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_SEL_W-1:0]  wb_sel;
    logic [WB_DATA_W-1:0] wb_dat_o;
    logic [WB_DATA_W-1:0] wb_dat_i = '0;
    logic                 wb_ack   = 1'b0;
    logic                 wb_err   = 1'b0;

    logic [31:0] mem [0:63];   // model memory, word indexed
    logic [1:0]  wait_left;
    logic        ack_withheld;
    integer      seed;
    int          errors;
    int          requests;
    int          done_pulses;

    mem_stage i_mem_stage (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // wishbone slave with 0 to 3 wait states
    always @(posedge clk) begin
        wb_ack <= 1'b0;
        if (rst) begin
            wait_left <= 2'd0;
            for (int i = 0; i < 64; i++) begin
                mem[i] = 32'h9e37_79b1 * (i + 1);
            end
        end else if (wb_cyc && wb_stb && !wb_ack && !ack_withheld) begin
            if (wait_left == 2'd0) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_we && wb_sel[b]) begin
                        mem[wb_adr[7:2]][8*b +: 8] = wb_dat_o[8*b +: 8];
                    end
                end
                wb_dat_i  <= mem[wb_adr[7:2]];
                wb_ack    <= 1'b1;
                wait_left <= 2'($random(seed));
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && done) begin
            done_pulses++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    task automatic check(input bit ok, input string what);
        assert (ok) else begin
            $display("ERROR %0t: %s", $time, what);
            errors++;
        end
    endtask

    function automatic logic [31:0] make_ctr(input logic [3:0] typ, input logic [4:0] sub,
                                             input bit ld, input bit st);
        logic [31:0] c;
        c                          = '0;
        c[CTR_TYPE_HI:CTR_TYPE_LO] = typ;
        c[CTR_SUB_HI:CTR_SUB_LO]   = sub;
        c[CTR_LOAD_BIT]            = ld;
        c[CTR_STORE_BIT]           = st;
        return c;
    endfunction

    // lanes touched by an access, none when misaligned
    function automatic logic [3:0] lanes_for(input logic [1:0] sz, input logic [1:0] off);
        case (sz)
            SIZE_BYTE: return 4'b0001 << off;
            SIZE_HALF: return (off == 2'd0) ? 4'b0011 : (off == 2'd2) ? 4'b1100 : 4'b0000;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] place_lanes(input logic [31:0] data, input logic [1:0] sz);
        case (sz)
            SIZE_BYTE: return {4{data[7:0]}};
            SIZE_HALF: return {2{data[15:0]}};
            default:   return data;
        endcase
    endfunction

    function automatic logic [31:0] extend_lane(input logic [31:0] word, input logic [1:0] sz,
                                                input bit sgn, input logic [1:0] off);
        logic [31:0] shifted;
        shifted = word >> (8 * off);
        case (sz)
            SIZE_BYTE: return sgn ? {{24{shifted[7]}}, shifted[7:0]} : {24'h0, shifted[7:0]};
            SIZE_HALF: return sgn ? {{16{shifted[15]}}, shifted[15:0]} : {16'h0, shifted[15:0]};
            default:   return word;
        endcase
    endfunction

    // drives one request and waits for done, checking the bus cycle on the way
    task automatic send_request(input logic [31:0] c, input logic [31:0] base,
                                input logic [1:0] off, input logic [31:0] data,
                                input logic [15:0] arg, input bit hold,
                                input logic [3:0] exp_sel, input logic [31:0] exp_dat,
                                input bit exp_we, output int cycles, output bit saw_cyc);
        logic [31:0] mask;
        logic [31:0] junk;
        mask = {{8{exp_sel[3]}}, {8{exp_sel[2]}}, {8{exp_sel[1]}}, {8{exp_sel[0]}}};
        junk = $random(seed);
        @(posedge clk);
        issue    <= 1'b1;
        ctr      <= c;
        rrj      <= base;
        imm      <= {30'h0, off};
        rrd      <= data;
        excp_arg <= arg;
        @(posedge clk);
        requests++;
        if (hold) begin
            rrd <= junk;   // ignored while busy
            imm <= {junk[31:2], 2'b01};
        end else begin
            issue <= 1'b0;
        end
        cycles  = 0;
        saw_cyc = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            check(busy, "busy low while a request was in flight");
            if (wb_cyc) begin
                saw_cyc = 1'b1;
                check(wb_stb && wb_sel == exp_sel && wb_we == exp_we
                      && wb_adr == {base[31:2], 2'b00}
                      && (!exp_we || ((wb_dat_o ^ exp_dat) & mask) == 32'h0),
                      $sformatf("bus cycle sel %b adr %h dat %h wrong", wb_sel, wb_adr, wb_dat_o));
            end
        end while (!done);
    endtask

    task automatic release_issue();
        @(posedge clk);
        issue <= 1'b0;
    endtask

    task automatic store_test(input logic [4:0] sub, input logic [1:0] sz,
                              input logic [1:0] off, input bit hold);
        logic [31:0] base;
        logic [31:0] data;
        logic [31:0] placed;
        logic [31:0] after_exp;
        logic [3:0]  sel;
        int          cycles;
        bit          saw_cyc;
        base      = $random(seed) & 32'h0000_00fc;
        data      = $random(seed);
        sel       = lanes_for(sz, off);
        placed    = place_lanes(data, sz);
        after_exp = mem[base[7:2]];
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                after_exp[8*b +: 8] = placed[8*b +: 8];
            end
        end
        send_request(make_ctr(TYPE_MEM, sub, 1'b0, 1'b1), base, off, data, 16'h0, hold,
                     sel, placed, 1'b1, cycles, saw_cyc);
        if (sel == 4'b0000) begin
            check(align_error && !saw_cyc && cycles == 1,
                  "misaligned store did not end with align_error after one cycle");
        end else begin
            check(saw_cyc && !align_error && !bus_error && load_data == 32'h0,
                  $sformatf("store sub %0d offset %0d ended wrongly", sub, off));
        end
        check(mem[base[7:2]] == after_exp,
              $sformatf("memory holds %h after store, expected %h", mem[base[7:2]], after_exp));
        if (hold) begin
            release_issue();
        end
    endtask

    task automatic load_test(input logic [3:0] typ, input logic [4:0] sub, input logic [1:0] sz,
                             input bit sgn, input logic [1:0] off, input bit hold);
        logic [31:0] base;
        logic [31:0] exp_val;
        logic [3:0]  sel;
        int          cycles;
        bit          saw_cyc;
        base    = $random(seed) & 32'h0000_00fc;
        sel     = lanes_for(sz, off);
        exp_val = extend_lane(mem[base[7:2]], sz, sgn, off);
        send_request(make_ctr(typ, sub, 1'b1, 1'b0), base, off, 32'h0, 16'h0, hold,
                     sel, 32'h0, 1'b0, cycles, saw_cyc);
        if (sel == 4'b0000) begin
            check(align_error && !saw_cyc && cycles == 1,
                  "misaligned load did not end with align_error after one cycle");
        end else begin
            check(saw_cyc && !align_error && !bus_error && load_data == exp_val,
                  $sformatf("load sub %0d offset %0d gave %h, expected %h",
                            sub, off, load_data, exp_val));
        end
        if (hold) begin
            release_issue();
        end
    endtask

    task automatic cache_test(input bit is_bar, input logic [2:0] kind);
        logic [15:0] arg;
        logic [31:0] c;
        logic [31:0] exp_opcode;
        logic [2:0]  exp_flags;   // icache, dcache, l2
        int          cycles;
        bit          saw_cyc;
        arg      = 16'($random(seed));
        arg[2:0] = kind;
        if (is_bar) begin
            c          = make_ctr(TYPE_BAR, 5'd0, 1'b0, 1'b0);
            exp_opcode = OPCODE_IBAR;
            exp_flags  = 3'b100;
        end else begin
            c          = make_ctr(TYPE_MEM, SUB_CACOP, 1'b0, 1'b0);
            exp_opcode = {16'h0, arg};
            exp_flags  = {kind == CACOP_ICACHE, kind == CACOP_DCACHE, 1'b1};
        end
        send_request(c, 32'h0, 2'd0, 32'h0, arg, 1'b0, 4'b0000, 32'h0, 1'b0, cycles, saw_cyc);
        check(cache_op_valid && cycles == 1 && !saw_cyc && cache_opcode == exp_opcode
              && {icache_op, dcache_op, l2cache_op} == exp_flags,
              $sformatf("cache op kind %0d bar %0d gave flags %b opcode %h", kind, is_bar,
                        {icache_op, dcache_op, l2cache_op}, cache_opcode));
    endtask

    task automatic timeout_test();
        logic [31:0] base;
        int          cycles;
        bit          saw_cyc;
        base         = $random(seed) & 32'h0000_00fc;
        ack_withheld = 1'b1;
        send_request(make_ctr(TYPE_MEM, SUB_LD_W, 1'b1, 1'b0), base, 2'd0, 32'h0, 16'h0, 1'b0,
                     4'b1111, 32'h0, 1'b0, cycles, saw_cyc);
        check(bus_error && !wb_cyc && saw_cyc && cycles > BUS_TIMEOUT,
              "withheld acknowledge did not end in bus_error");
        ack_withheld = 1'b0;
    endtask

    initial begin
        seed         = 32'h8179e1c8;
        errors       = 0;
        requests     = 0;
        done_pulses  = 0;
        ack_withheld = 1'b0;
        rst          = 1'b1;
        issue        = 1'b0;
        ctr          = '0;
        rrj          = '0;
        imm          = '0;
        rrd          = '0;
        excp_arg     = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < ROUNDS; r++) begin
            for (int o = 0; o < 4; o++) begin
                store_test(SUB_ST_B, SIZE_BYTE, 2'(o), 1'b0);
                store_test(SUB_ST_H, SIZE_HALF, 2'(o), 1'b0);
                store_test(SUB_ST_W, SIZE_WORD, 2'(o), 1'b0);
                load_test(TYPE_MEM, SUB_LD_B, SIZE_BYTE, 1'b1, 2'(o), 1'b0);
                load_test(TYPE_MEM, SUB_LD_H, SIZE_HALF, 1'b1, 2'(o), 1'b0);
                load_test(TYPE_MEM, SUB_LD_W, SIZE_WORD, 1'b0, 2'(o), 1'b0);
                load_test(TYPE_MEM, SUB_LD_BU, SIZE_BYTE, 1'b0, 2'(o), 1'b0);
                load_test(TYPE_MEM, SUB_LD_HU, SIZE_HALF, 1'b0, 2'(o), 1'b0);
                load_test(TYPE_ATOMIC, SUB_LL_W, SIZE_WORD, 1'b0, 2'(o), 1'b0);
            end
        end
        cache_test(1'b0, CACOP_ICACHE);
        cache_test(1'b0, CACOP_DCACHE);
        cache_test(1'b0, CACOP_L2);
        cache_test(1'b1, 3'd0);
        timeout_test();
        store_test(SUB_ST_W, SIZE_WORD, 2'd0, 1'b1);   // issue held high while busy
        load_test(TYPE_MEM, SUB_LD_H, SIZE_HALF, 1'b1, 2'd2, 1'b1);
        repeat (20) @(posedge clk);
        check(done_pulses == requests,
              $sformatf("%0d done pulses for %0d accepted requests", done_pulses, requests));
        $display("errors: %0d  requests: %0d  done pulses: %0d", errors, requests, done_pulses);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/mem_stage_props.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_props (
    input wire logic                         clk,
    input wire logic                         rst,
    input wire logic                         busy,
    input wire logic                         done,
    input wire logic                         wb_cyc,
    input wire logic                         wb_stb,
    input wire logic                         wb_ack,
    input wire logic                         wb_err,
    input wire logic                         timeout,
    input wire logic [wb_pkg::WB_ADDR_W-1:0] wb_adr,
    input wire logic [wb_pkg::WB_SEL_W-1:0]  wb_sel,
    input wire logic [wb_pkg::WB_DATA_W-1:0] wb_dat_o
);

    // strobe keeps cyc and itself up until ack, err or timeout
    a_cyc_hold: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack && !wb_err && !timeout |=> wb_cyc && wb_stb)
        else $error("wb_cyc or wb_stb dropped before ack, error or timeout");

    // classic cycle holds its fields until ack
    a_stable: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack && !wb_err |=> $stable(wb_adr) && $stable(wb_sel) && $stable(wb_dat_o))
        else $error("address, select or data changed while the strobe waited");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !wb_cyc && !wb_stb && !busy && !done)
        else $error("stage not idle when reset was released");

endmodule

bind mem_stage mem_stage_props i_mem_stage_props (
    .clk      (clk),
    .rst      (rst),
    .busy     (busy),
    .done     (done),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .wb_err   (wb_err),
    .timeout  (timeout),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_o (wb_dat_o)
);

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue,
    input  logic [31:0]                  ctr,
    input  logic [31:0]                  rrj,
    input  logic [31:0]                  imm,
    input  logic [31:0]                  rrd,
    input  logic [15:0]                  excp_arg,
    output logic                         busy,
    output logic                         done,
    output logic [wb_pkg::WB_DATA_W-1:0] load_data,
    output logic                         align_error,
    output logic                         bus_error,
    output logic                         cache_op_valid,
    output logic [31:0]                  cache_opcode,
    output logic                         icache_op,
    output logic                         dcache_op,
    output logic                         l2cache_op,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic [wb_pkg::WB_ADDR_W-1:0] wb_adr,
    output logic [wb_pkg::WB_SEL_W-1:0]  wb_sel,
    output logic [wb_pkg::WB_DATA_W-1:0] wb_dat_o,
    input  logic [wb_pkg::WB_DATA_W-1:0] wb_dat_i,
    input  logic                         wb_ack,
    input  logic                         wb_err
);
    import wb_pkg::*;

    logic [WB_ADDR_W-1:0] addr;
    logic [WB_DATA_W-1:0] store_data;
    logic [WB_DATA_W-1:0] load_value;
    logic [WB_SEL_W-1:0]  wstrb;
    logic [1:0]           size;
    logic [1:0]           reg_size;
    logic                 we;
    logic                 mem_valid;
    logic                 load_signed;
    logic                 reg_signed;
    logic                 timeout;
    logic [31:0]          dec_cache_opcode; // decoder side, before registering
    logic                 dec_icache_op;
    logic                 dec_dcache_op;
    logic                 dec_l2cache_op;

    cache_ctr i_cache_ctr (
        .rrj          (rrj),
        .imm          (imm),
        .ctr          (ctr),
        .rrd          (rrd),
        .excp_arg     (excp_arg),
        .addr         (addr),
        .store_data   (store_data),
        .we           (we),
        .mem_valid    (mem_valid),
        .wstrb        (wstrb),
        .size         (size),
        .cache_opcode (dec_cache_opcode),
        .dcache_op    (dec_dcache_op),
        .icache_op    (dec_icache_op),
        .l2cache_op   (dec_l2cache_op),
        .load_signed  (load_signed)
    );

    mem_access_fsm i_mem_access_fsm (
        .clk              (clk),
        .rst              (rst),
        .issue            (issue),
        .addr             (addr),
        .store_data       (store_data),
        .we               (we),
        .mem_valid        (mem_valid),
        .wstrb            (wstrb),
        .size             (size),
        .load_signed      (load_signed),
        .cache_opcode     (dec_cache_opcode),
        .icache_op        (dec_icache_op),
        .dcache_op        (dec_dcache_op),
        .l2cache_op       (dec_l2cache_op),
        .load_value       (load_value),
        .wb_ack           (wb_ack),
        .wb_err           (wb_err),
        .timeout          (timeout),
        .busy             (busy),
        .done             (done),
        .load_data        (load_data),
        .align_error      (align_error),
        .bus_error        (bus_error),
        .cache_op_valid   (cache_op_valid),
        .reg_cache_opcode (cache_opcode),
        .reg_icache_op    (icache_op),
        .reg_dcache_op    (dcache_op),
        .reg_l2cache_op   (l2cache_op),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_sel           (wb_sel),
        .wb_dat_o         (wb_dat_o),
        .reg_size         (reg_size),
        .reg_signed       (reg_signed)
    );

    bus_timeout i_bus_timeout (
        .clk     (clk),
        .rst     (rst),
        .wb_stb  (wb_stb),
        .wb_ack  (wb_ack),
        .timeout (timeout)
    );

    load_align i_load_align (
        .wb_dat_i    (wb_dat_i),
        .sel         (wb_sel),
        .size        (reg_size),
        .load_signed (reg_signed),
        .load_value  (load_value)
    );

endmodule

`default_nettype wire

// File: rtl/mem_access_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue,
    input  logic [wb_pkg::WB_ADDR_W-1:0] addr,
    input  logic [wb_pkg::WB_DATA_W-1:0] store_data,
    input  logic                         we,
    input  logic                         mem_valid,
    input  logic [wb_pkg::WB_SEL_W-1:0]  wstrb,
    input  logic [1:0]                   size,
    input  logic                         load_signed,
    input  logic [31:0]                  cache_opcode,
    input  logic                         icache_op,
    input  logic                         dcache_op,
    input  logic                         l2cache_op,
    input  logic [wb_pkg::WB_DATA_W-1:0] load_value,
    input  logic                         wb_ack,
    input  logic                         wb_err,
    input  logic                         timeout,
    output logic                         busy,
    output logic                         done,
    output logic [wb_pkg::WB_DATA_W-1:0] load_data,
    output logic                         align_error,
    output logic                         bus_error,
    output logic                         cache_op_valid,
    output logic [31:0]                  reg_cache_opcode,
    output logic                         reg_icache_op,
    output logic                         reg_dcache_op,
    output logic                         reg_l2cache_op,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic [wb_pkg::WB_ADDR_W-1:0] wb_adr,
    output logic [wb_pkg::WB_SEL_W-1:0]  wb_sel,
    output logic [wb_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic [1:0]                   reg_size,
    output logic                         reg_signed
);
    import wb_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_FINISH
    } state_t;

    state_t state;
    logic   fin_align;
    logic   fin_cache;
    logic   fin_bus_err;
    logic   accept;
    logic   is_cache;
    logic   run_bus;

    assign accept   = issue && !busy;
    assign is_cache = icache_op | dcache_op | l2cache_op;
    assign run_bus  = !is_cache && mem_valid && (wstrb != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            fin_align   <= 1'b0;
            fin_cache   <= 1'b0;
            fin_bus_err <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        fin_cache   <= is_cache;
                        fin_align   <= !is_cache && mem_valid && (wstrb == '0);
                        fin_bus_err <= 1'b0;
                        state       <= run_bus ? S_BUS : S_FINISH; // non-mem op just finishes
                    end
                end
                S_BUS: begin
                    if (wb_ack) begin
                        state <= S_FINISH;
                    end else if (wb_err || timeout) begin
                        fin_bus_err <= 1'b1;
                        state       <= S_FINISH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_adr           <= {addr[WB_ADDR_W-1:2], 2'b00};
            wb_sel           <= wstrb;
            wb_we            <= we;
            wb_dat_o         <= store_data;
            reg_size         <= size;
            reg_signed       <= load_signed;
            reg_cache_opcode <= cache_opcode;
            reg_icache_op    <= icache_op;
            reg_dcache_op    <= dcache_op;
            reg_l2cache_op   <= l2cache_op;
            load_data        <= '0;
        end else if (state == S_BUS && wb_ack && !wb_we) begin
            load_data <= load_value; // aligned lane from load_align
        end
    end

    assign busy           = (state != S_IDLE);
    assign done           = (state == S_FINISH);
    assign align_error    = done && fin_align;
    assign bus_error      = done && fin_bus_err;
    assign cache_op_valid = done && fin_cache;
    assign wb_cyc         = (state == S_BUS);
    assign wb_stb         = (state == S_BUS);

endmodule

`default_nettype wire

// File: rtl/load_align.sv
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  sel,
    input  logic [1:0]  size,
    input  logic        load_signed,
    output logic [31:0] load_value
);
    import mem_op_pkg::*;

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    logic        ext_byte;
    logic        ext_half;

    always_comb begin
        case (sel)
            4'b0010: lane_byte = wb_dat_i[15:8];
            4'b0100: lane_byte = wb_dat_i[23:16];
            4'b1000: lane_byte = wb_dat_i[31:24];
            default: lane_byte = wb_dat_i[7:0];
        endcase
        lane_half = sel[3] ? wb_dat_i[31:16] : wb_dat_i[15:0]; // upper half at offset 2
    end

    assign ext_byte = load_signed & lane_byte[7];
    assign ext_half = load_signed & lane_half[15];

    always_comb begin
        case (size)
            SIZE_BYTE: load_value = {{24{ext_byte}}, lane_byte};
            SIZE_HALF: load_value = {{16{ext_half}}, lane_half};
            default:   load_value = wb_dat_i; // word
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/bus_timeout.sv
`timescale 1ns/100ps
`default_nettype none

module bus_timeout (
    input  logic clk,
    input  logic rst,
    input  logic wb_stb,
    input  logic wb_ack,
    output logic timeout
);
    import wb_pkg::*;

    logic [TIMEOUT_W-1:0] wait_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (!wb_stb || wb_ack) begin
            wait_cnt <= '0;
        end else if (!timeout) begin
            wait_cnt <= wait_cnt + 1'b1; // saturates at limit
        end
    end

    assign timeout = (wait_cnt == TIMEOUT_W'(BUS_TIMEOUT));

endmodule

`default_nettype wire

// File: rtl/cache_ctr.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctr (
    input  logic [31:0] rrj,
    input  logic [31:0] imm,
    input  logic [31:0] ctr,
    input  logic [31:0] rrd,
    input  logic [15:0] excp_arg,
    output logic [31:0] addr,
    output logic [31:0] store_data,
    output logic        we,          // 0 read, 1 write
    output logic        mem_valid,
    output logic [3:0]  wstrb,
    output logic [1:0]  size,
    output logic [31:0] cache_opcode,
    output logic        dcache_op,
    output logic        icache_op,
    output logic        l2cache_op,
    output logic        load_signed  // ld.b and ld.h
);
    import mem_op_pkg::*;

    logic [3:0] op_type;
    logic [4:0] subtype;
    logic [3:0] byte_lane;
    logic [3:0] half_lane;

    assign addr    = rrj + imm;
    assign op_type = ctr[CTR_TYPE_HI:CTR_TYPE_LO];
    assign subtype = ctr[CTR_SUB_HI:CTR_SUB_LO];

    always_comb begin
        byte_lane = 4'b0001 << addr[1:0]; // little endian lanes
        case (addr[1:0])
            2'b00:   half_lane = 4'b0011;
            2'b10:   half_lane = 4'b1100;
            default: half_lane = 4'b0000; // misaligned, no strobes
        endcase
    end

    always_comb begin
        store_data   = '0;
        we           = ctr[CTR_STORE_BIT];
        mem_valid    = ctr[CTR_STORE_BIT] | ctr[CTR_LOAD_BIT];
        wstrb        = '0;
        size         = SIZE_BYTE;
        cache_opcode = '0;
        dcache_op    = 1'b0;
        icache_op    = 1'b0;
        l2cache_op   = 1'b0;
        load_signed  = 1'b0;
        if (op_type == TYPE_MEM) begin
            case (subtype)
                SUB_LD_B, SUB_LD_BU: begin
                    wstrb       = byte_lane;
                    load_signed = (subtype == SUB_LD_B);
                end
                SUB_LD_H, SUB_LD_HU: begin
                    wstrb       = half_lane;
                    size        = SIZE_HALF;
                    load_signed = (subtype == SUB_LD_H);
                end
                SUB_LD_W: begin
                    wstrb = 4'b1111;
                    size  = SIZE_WORD;
                end
                SUB_ST_B: begin
                    wstrb      = byte_lane;
                    store_data = {24'b0, rrd[7:0]} << {addr[1:0], 3'b000};
                end
                SUB_ST_H: begin
                    wstrb      = half_lane;
                    size       = SIZE_HALF;
                    store_data = {16'b0, rrd[15:0]} << {addr[1], 4'b0000};
                end
                SUB_ST_W: begin
                    wstrb      = 4'b1111;
                    size       = SIZE_WORD;
                    store_data = rrd;
                end
                SUB_CACOP: begin
                    mem_valid    = 1'b0;
                    we           = 1'b0;
                    cache_opcode = {16'b0, excp_arg};
                    case (excp_arg[2:0])
                        CACOP_ICACHE: begin
                            icache_op  = 1'b1;
                            l2cache_op = 1'b1;
                        end
                        CACOP_DCACHE: begin
                            dcache_op  = 1'b1;
                            l2cache_op = 1'b1;
                        end
                        CACOP_L2: l2cache_op = 1'b1;
                        default: ; // other kinds touch no cache
                    endcase
                end
                default: ;
            endcase
        end else if (op_type == TYPE_ATOMIC) begin
            // ll.w and sc.w run as plain word accesses
            if (subtype == SUB_LL_W || subtype == SUB_SC_W) begin
                wstrb = 4'b1111;
                size  = SIZE_WORD;
            end
            if (subtype == SUB_SC_W) begin
                store_data = rrd;
            end
        end else if (op_type == TYPE_BAR) begin
            mem_valid    = 1'b0;
            we           = 1'b0;
            cache_opcode = OPCODE_IBAR;
            icache_op    = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int WB_ADDR_W = 32;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 4;

    // cycles a strobe may wait for ack
    localparam int BUS_TIMEOUT = 16;
    localparam int TIMEOUT_W   = 5; // must hold BUS_TIMEOUT

endpackage

`default_nettype wire

// File: rtl/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

    // pipeline control word layout
    localparam int CTR_TYPE_LO   = 0;
    localparam int CTR_TYPE_HI   = 3;
    localparam int CTR_LOAD_BIT  = 4;
    localparam int CTR_STORE_BIT = 5;
    localparam int CTR_SUB_LO    = 7;
    localparam int CTR_SUB_HI    = 11;

    localparam logic [3:0] TYPE_MEM    = 4'd5;
    localparam logic [3:0] TYPE_ATOMIC = 4'd6;
    localparam logic [3:0] TYPE_BAR    = 4'd9;

    localparam logic [4:0] SUB_LD_B  = 5'd0;
    localparam logic [4:0] SUB_LD_H  = 5'd1;
    localparam logic [4:0] SUB_LD_W  = 5'd2;
    localparam logic [4:0] SUB_ST_B  = 5'd3;
    localparam logic [4:0] SUB_ST_H  = 5'd4;
    localparam logic [4:0] SUB_ST_W  = 5'd5;
    localparam logic [4:0] SUB_LD_BU = 5'd6;
    localparam logic [4:0] SUB_LD_HU = 5'd7;
    localparam logic [4:0] SUB_CACOP = 5'd8;
    localparam logic [4:0] SUB_LL_W  = 5'd11; // atomic type only
    localparam logic [4:0] SUB_SC_W  = 5'd12;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // cacop kind, low bits of excp_arg
    localparam logic [2:0] CACOP_ICACHE = 3'd0;
    localparam logic [2:0] CACOP_DCACHE = 3'd1;
    localparam logic [2:0] CACOP_L2     = 3'd2;

    localparam logic [31:0] OPCODE_IBAR = 32'h8000_0000;

endpackage

`default_nettype wire
